// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - exec_ctrl_pkg.sv
      - alu_unit.sv
      - branch_unit.sv
      - load_store_unit.sv
      - trap_tag_ctrl.sv
      - exec_stage.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - exec_stage_sva.sv
      - exec_stage_tb.sv

// File: alu_unit.sv
// Integer ALU with main adder, second adder, compare flags and result select

`default_nettype none

`include "exec_stage_macros.svh"

module alu_unit
    import rv_isa_pkg::*;
(
    input  op_e   op_i,
    input  word_t pc_i,
    input  word_t first_operand_i,
    input  word_t second_operand_i,
    input  word_t third_operand_i,
    output word_t sum_result_o,
    output word_t link_result_o,
    output word_t result_o,
    output logic  equal_o,
    output logic  less_than_o,
    output logic  less_than_unsigned_o
);

    word_t                adder2_a;
    word_t                adder2_b;
    word_t                and_result;
    word_t                or_result;
    word_t                xor_result;
    word_t                sll_result;
    word_t                srl_result;
    word_t                sra_result;
    logic [`SHAMT_W-1:0]  shamt;

    ////////////////////////////////////////
    // Adders
    ////////////////////////////////////////

    // Second adder operands, SUB uses two's complement of op B
    always_comb begin
        unique case (op_i)
            SUB: begin
                adder2_a = first_operand_i;
                adder2_b = ~second_operand_i + 1'b1;
            end
            JAL, JALR: begin
                adder2_a = pc_i;
                adder2_b = word_t'(`PC_STEP);
            end
            default: begin
                adder2_a = pc_i;
                adder2_b = third_operand_i;
            end
        endcase
    end

    assign sum_result_o  = first_operand_i + second_operand_i;
    assign link_result_o = adder2_a + adder2_b;

    ////////////////////////////////////////
    // Logic, shifts and compares
    ////////////////////////////////////////

    assign shamt      = second_operand_i[`SHAMT_W-1:0];
    assign and_result = first_operand_i & second_operand_i;
    assign or_result  = first_operand_i | second_operand_i;
    assign xor_result = first_operand_i ^ second_operand_i;
    assign sll_result = first_operand_i << shamt;
    assign srl_result = first_operand_i >> shamt;
    assign sra_result = $signed(first_operand_i) >>> shamt;

    assign equal_o              = (first_operand_i == second_operand_i);
    assign less_than_o          = ($signed(first_operand_i) < $signed(second_operand_i));
    assign less_than_unsigned_o = (first_operand_i < second_operand_i);

    // Result select
    always_comb begin
        unique case (op_i)
            SUB, JAL, JALR: result_o = link_result_o;
            SLT:            result_o = {{(`XLEN-1){1'b0}}, less_than_o};
            SLTU:           result_o = {{(`XLEN-1){1'b0}}, less_than_unsigned_o};
            XOR:            result_o = xor_result;
            OR:             result_o = or_result;
            AND:            result_o = and_result;
            SLL:            result_o = sll_result;
            SRL:            result_o = srl_result;
            SRA:            result_o = sra_result;
            LUI:            result_o = second_operand_i;
            default:        result_o = sum_result_o;
        endcase
    end

endmodule

`default_nettype wire

// File: branch_unit.sv
// Branch decision and jump target formation for the execute stage

`default_nettype none

`include "exec_stage_macros.svh"

module branch_unit
    import rv_isa_pkg::*;
(
    input  op_e   op_i,
    input  word_t sum_result_i,
    input  word_t link_result_i,
    input  logic  equal_i,
    input  logic  less_than_i,
    input  logic  less_than_unsigned_i,
    input  logic  killed_i,
    output logic  jump_o,
    output word_t jump_target_o
);

    logic take;

    // Condition evaluation, GE is the inverse of LT
    always_comb begin
        unique case (op_i)
            BEQ:       take = equal_i;
            BNE:       take = ~equal_i;
            BLT:       take = less_than_i;
            BLTU:      take = less_than_unsigned_i;
            BGE:       take = ~less_than_i;
            BGEU:      take = ~less_than_unsigned_i;
            JAL, JALR: take = 1'b1;
            default:   take = 1'b0;
        endcase
    end

    // A stale instruction never redirects
    assign jump_o = take & ~killed_i;

    ////////////////////////////////////////
    // Target
    ////////////////////////////////////////

    // Branch targets come from pc + imm on the second adder
    always_comb begin
        unique case (op_i)
            JALR:    jump_target_o = {sum_result_i[`XLEN-1:1], 1'b0};
            JAL:     jump_target_o = sum_result_i;
            default: jump_target_o = link_result_i;
        endcase
    end

endmodule

`default_nettype wire

// File: exec_ctrl_pkg.sv
// Pipeline-control types for the execute stage: flow tag, trap cause, byte mask

`default_nettype none

`include "exec_stage_macros.svh"

package exec_ctrl_pkg;

    // Flow tag, bumped on every redirect
    typedef logic [`TAG_W-1:0] tag_t;

    // Trap cause, using the RISC-V mcause values
    // NE sits outside the used cause range
    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        ECALL_FROM_MMODE               = 5'd11,
        NE                             = 5'd31
    } exc_code_e;

    // One bit per byte lane of a store
    typedef logic [`BE_W-1:0] byte_en_t;

endpackage

`default_nettype wire

// File: exec_stage.f
+incdir+.
rv_isa_pkg.sv
exec_ctrl_pkg.sv
alu_unit.sv
branch_unit.sv
load_store_unit.sv
trap_tag_ctrl.sv
exec_stage.sv
exec_stage_sva.sv
exec_stage_tb.sv

// File: exec_stage.sv
// Execute stage top: ALU, branch, load-store, trap control and writeback registers

`default_nettype none

module exec_stage
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  word_t     pc_i,
    input  word_t     first_operand_i,
    input  word_t     second_operand_i,
    input  word_t     third_operand_i,
    input  op_e       operation_i,
    input  tag_t      tag_i,
    input  logic      exc_illegal_inst_i,
    input  logic      exc_misaligned_fetch_i,
    input  logic      interrupt_pending_i,
    output logic      killed_o,
    output logic      write_enable_o,
    output op_e       operation_o,
    output word_t     result_o,
    output word_t     mem_address_o,
    output logic      mem_read_enable_o,
    output byte_en_t  mem_write_enable_o,
    output word_t     mem_write_data_o,
    output logic      jump_o,
    output word_t     jump_target_o,
    output logic      raise_exception_o,
    output logic      machine_return_o,
    output logic      interrupt_ack_o,
    output exc_code_e exception_code_o
);

    word_t sum_result;
    word_t link_result;
    word_t alu_result;
    logic  equal;
    logic  less_than;
    logic  less_than_unsigned;
    logic  write_enable;

    alu_unit alu_unit_inst (
        .op_i                 (operation_i),
        .pc_i                 (pc_i),
        .first_operand_i      (first_operand_i),
        .second_operand_i     (second_operand_i),
        .third_operand_i      (third_operand_i),
        .sum_result_o         (sum_result),
        .link_result_o        (link_result),
        .result_o             (alu_result),
        .equal_o              (equal),
        .less_than_o          (less_than),
        .less_than_unsigned_o (less_than_unsigned)
    );

    branch_unit branch_unit_inst (
        .op_i                 (operation_i),
        .sum_result_i         (sum_result),
        .link_result_i        (link_result),
        .equal_i              (equal),
        .less_than_i          (less_than),
        .less_than_unsigned_i (less_than_unsigned),
        .killed_i             (killed_o),
        .jump_o               (jump_o),
        .jump_target_o        (jump_target_o)
    );

    load_store_unit load_store_unit_inst (
        .op_i               (operation_i),
        .sum_result_i       (sum_result),
        .third_operand_i    (third_operand_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    trap_tag_ctrl trap_tag_ctrl_inst (
        .clk                    (clk),
        .reset                  (reset),
        .op_i                   (operation_i),
        .tag_i                  (tag_i),
        .exc_illegal_inst_i     (exc_illegal_inst_i),
        .exc_misaligned_fetch_i (exc_misaligned_fetch_i),
        .interrupt_pending_i    (interrupt_pending_i),
        .jump_i                 (jump_o),
        .killed_o               (killed_o),
        .raise_exception_o      (raise_exception_o),
        .machine_return_o       (machine_return_o),
        .interrupt_ack_o        (interrupt_ack_o),
        .exception_code_o       (exception_code_o)
    );

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    // Stores and branches have no destination register
    always_comb begin
        unique case (operation_i)
            SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default:                        write_enable = ~killed_o;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
            operation_o    <= NOP;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            operation_o    <= operation_i;
        end
    end

    // Result only matters when write_enable_o is set
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: exec_stage_macros.svh
// Execute stage widths and fixed constants shared by packages and RTL

`ifndef EXEC_STAGE_MACROS_SVH
`define EXEC_STAGE_MACROS_SVH

// Data and address width
`define XLEN 32

// Flow tag width, wraps around on overflow
`define TAG_W 3

// Shift amount taken from the low operand bits
`define SHAMT_W 5

// Link address step for JAL and JALR
`define PC_STEP 4

// Byte lanes per data word
`define BE_W 4

`endif

// File: exec_stage_sva.sv
// Concurrent checks on trap exclusivity, kill suppression and reset behavior

`default_nettype none

module exec_stage_sva (
    input logic clk,
    input logic reset,
    input logic killed_i,
    input logic jump_i,
    input logic raise_exception_i,
    input logic machine_return_i,
    input logic interrupt_ack_i
);

    int unsigned failures = 0;

    // At most one trap outcome per cycle
    assert property (@(posedge clk)
        $onehot0({raise_exception_i, machine_return_i, interrupt_ack_i}))
        else begin
            failures++;
            $error("trap outputs are not mutually exclusive");
        end

    // Stale flow neither redirects nor traps
    assert property (@(posedge clk) disable iff (reset)
        killed_i |-> !(jump_i || raise_exception_i || machine_return_i || interrupt_ack_i))
        else begin
            failures++;
            $error("killed instruction produced a jump or a trap");
        end

    assert property (@(posedge clk)
        reset |-> !(raise_exception_i || machine_return_i || interrupt_ack_i))
        else begin
            failures++;
            $error("trap output high during reset");
        end

endmodule

`default_nettype wire

// File: exec_stage_tb.sv
// Testbench for the execute stage with reference model, random stimulus and checks

`default_nettype none

`include "exec_stage_macros.svh"

module exec_stage_tb
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
();

    typedef struct packed {
        word_t    result;
        logic     we;
        logic     jump;
        word_t    target;
        word_t    addr;
        logic     rd_en;
        byte_en_t be;
        word_t    wdata;
        logic     killed;
        logic     raise;
        logic     mret;
        logic     irq_ack;
        logic [4:0] code;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      stall;
    word_t     pc;
    word_t     first_operand;
    word_t     second_operand;
    word_t     third_operand;
    op_e       operation;
    tag_t      tag;
    logic      exc_illegal;
    logic      exc_misaligned;
    logic      irq_pending;
    logic      killed;
    logic      write_enable;
    op_e       operation_q;
    word_t     result;
    word_t     mem_address;
    logic      mem_read_enable;
    byte_en_t  mem_write_enable;
    word_t     mem_write_data;
    logic      jump;
    word_t     jump_target;
    logic      raise_exception;
    logic      machine_return;
    logic      interrupt_ack;
    exc_code_e exception_code;

    // Model state and registered expectations
    tag_t      model_tag;
    logic      next_active;
    logic      next_we;
    op_e       next_op;
    word_t     next_result;
    logic      cur_active;
    logic      cur_we;
    op_e       cur_op;
    word_t     cur_result;
    int        errors;
    int        checks;
    int        tests;
    int        test_start_errors;
    logic      reset_ok;

    exec_stage exec_stage_inst (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall),
        .pc_i                   (pc),
        .first_operand_i        (first_operand),
        .second_operand_i       (second_operand),
        .third_operand_i        (third_operand),
        .operation_i            (operation),
        .tag_i                  (tag),
        .exc_illegal_inst_i     (exc_illegal),
        .exc_misaligned_fetch_i (exc_misaligned),
        .interrupt_pending_i    (irq_pending),
        .killed_o               (killed),
        .write_enable_o         (write_enable),
        .operation_o            (operation_q),
        .result_o               (result),
        .mem_address_o          (mem_address),
        .mem_read_enable_o      (mem_read_enable),
        .mem_write_enable_o     (mem_write_enable),
        .mem_write_data_o       (mem_write_data),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .raise_exception_o      (raise_exception),
        .machine_return_o       (machine_return),
        .interrupt_ack_o        (interrupt_ack),
        .exception_code_o       (exception_code)
    );

    bind exec_stage exec_stage_sva exec_stage_sva_inst (
        .clk                 (clk),
        .reset               (reset),
        .killed_i            (killed_o),
        .jump_i              (jump_o),
        .raise_exception_i   (raise_exception_o),
        .machine_return_i    (machine_return_o),
        .interrupt_ack_i     (interrupt_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic expect_t ref_model(input op_e op, input word_t pc_v, input word_t a,
        input word_t b, input word_t c, input tag_t tag_in, input tag_t tag_cur,
        input logic ill, input logic mis, input logic irq);
        expect_t e;
        word_t   sum;
        logic    taken;
        e = '0;
        sum = a + b;
        e.code = NE;
        e.killed = (tag_in != tag_cur);
        case (op)
            SUB:       e.result = a - b;
            SLT:       e.result = word_t'($signed(a) < $signed(b));
            SLTU:      e.result = word_t'(a < b);
            XOR:       e.result = a ^ b;
            OR:        e.result = a | b;
            AND:       e.result = a & b;
            SLL:       e.result = a << b[`SHAMT_W-1:0];
            SRL:       e.result = a >> b[`SHAMT_W-1:0];
            SRA:       e.result = $signed(a) >>> b[`SHAMT_W-1:0];
            LUI:       e.result = b;
            JAL, JALR: e.result = pc_v + `PC_STEP;
            default:   e.result = sum;
        endcase
        case (op)
            BEQ:       taken = (a == b);
            BNE:       taken = (a != b);
            BLT:       taken = ($signed(a) < $signed(b));
            BLTU:      taken = (a < b);
            BGE:       taken = ($signed(a) >= $signed(b));
            BGEU:      taken = (a >= b);
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
        e.jump = taken && !e.killed;
        case (op)
            JALR:    e.target = sum & ~32'h1;
            JAL:     e.target = sum;
            default: e.target = pc_v + c;
        endcase
        e.addr = sum & ~32'h3;
        case (op)
            LB, LBU, LH, LHU, LW: e.rd_en = 1'b1;
            default:              e.rd_en = 1'b0;
        endcase
        case (op)
            SB: begin
                e.wdata = {c[7:0], c[7:0], c[7:0], c[7:0]};
                e.be    = 4'b0001 << sum[1:0];
            end
            SH: begin
                e.wdata = {c[15:0], c[15:0]};
                e.be    = sum[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                e.wdata = c;
                e.be    = 4'b1111;
            end
            default: begin
                e.wdata = c;
                e.be    = 4'b0000;
            end
        endcase
        case (op)
            SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU: e.we = 1'b0;
            default:                                     e.we = !e.killed;
        endcase
        // Trap priority from highest to lowest
        if (!e.killed) begin
            if (ill) begin
                e.raise = 1'b1;
                e.code  = ILLEGAL_INSTRUCTION;
            end else if (mis) begin
                e.raise = 1'b1;
                e.code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op == ECALL) begin
                e.raise = 1'b1;
                e.code  = ECALL_FROM_MMODE;
            end else if (op == EBREAK) begin
                e.raise = 1'b1;
                e.code  = BREAKPOINT;
            end else if (op == MRET) begin
                e.mret = 1'b1;
            end else if (irq) begin
                e.irq_ack = 1'b1;
            end
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_be(input string name, input byte_en_t exp, input byte_en_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_code(input string name, input exc_code_e exp, input exc_code_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input op_e exp, input op_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // Registered outputs checked against the prediction of the previous cycle
    initial begin
        cur_active = 1'b0;
        forever begin
            @(posedge clk);
            cur_active = next_active;
            cur_we     = next_we;
            cur_op     = next_op;
            cur_result = next_result;
            #2;
            if (cur_active) begin
                check_bit("write_enable_o", cur_we, write_enable);
                check_op("operation_o", cur_op, operation_q);
                check_word("result_o", cur_result, result);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One instruction per cycle with inputs changing 1 unit after the edge
    task automatic step(input op_e op, input word_t pc_v, input word_t a, input word_t b,
        input word_t c, input logic ill, input logic mis, input logic irq, input logic stl,
        input logic stale);
        expect_t e;
        @(posedge clk);
        #1;
        reset          = 1'b0;
        stall          = stl;
        operation      = op;
        pc             = pc_v;
        first_operand  = a;
        second_operand = b;
        third_operand  = c;
        exc_illegal    = ill;
        exc_misaligned = mis;
        irq_pending    = irq;
        tag            = stale ? tag_t'(model_tag - 1'b1) : model_tag;
        #2;
        e = ref_model(op, pc_v, a, b, c, tag, model_tag, ill, mis, irq);
        check_bit("killed_o", e.killed, killed);
        check_bit("jump_o", e.jump, jump);
        if (e.jump) begin
            check_word("jump_target_o", e.target, jump_target);
        end
        check_word("mem_address_o", e.addr, mem_address);
        check_bit("mem_read_enable_o", e.rd_en, mem_read_enable);
        check_be("mem_write_enable_o", e.be, mem_write_enable);
        check_word("mem_write_data_o", e.wdata, mem_write_data);
        check_bit("raise_exception_o", e.raise, raise_exception);
        check_bit("machine_return_o", e.mret, machine_return);
        check_bit("interrupt_ack_o", e.irq_ack, interrupt_ack);
        check_code("exception_code_o", exc_code_e'(e.code), exception_code);
        if (!stl) begin
            next_active = 1'b1;
            next_we     = e.we;
            next_op     = op;
            next_result = e.result;
        end
        if (e.jump || e.raise || e.mret || e.irq_ack) begin
            model_tag = model_tag + 1'b1;
        end
    endtask

    task automatic plain_step(input op_e op, input logic stl, input logic stale);
        step(op, $urandom(), $urandom(), $urandom(), $urandom(), 1'b0, 1'b0, 1'b0, stl, stale);
    endtask

    // A flush cycle lets the last registered check land in the right test
    task automatic close_test(input string name);
        plain_step(NOP, 1'b0, 1'b0);
        tests++;
        $display("test %s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic wait_reset_state(output logic ok);
        int cycles;
        cycles = 0;
        while (!(write_enable === 1'b0 && operation_q === NOP && interrupt_ack === 1'b0)
               && cycles < 4) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (cycles < 4);
    endtask

    task automatic run_tests();
        word_t wa;
        op_e   op;
        int    n;
        repeat (200) plain_step(op_e'($urandom_range(int'(LUI), int'(ADD))), 1'b0, 1'b0);
        close_test("alu_random");

        repeat (200) begin
            wa = $urandom();
            op = op_e'($urandom_range(int'(BGEU), int'(JAL)));
            step(op, $urandom(), wa, ($urandom_range(3, 0) == 0) ? wa : $urandom(), $urandom(),
                 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        close_test("branch_jump");

        for (int o = int'(LB); o <= int'(SW); o++) begin
            for (int off = 0; off < 4; off++) begin
                wa = $urandom();
                step(op_e'(o), $urandom(), {wa[31:2], 2'b00},
                     {wa[15:0], wa[31:18], 2'(off)}, $urandom(),
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            end
        end
        close_test("load_store");

        // Taken jump, then stale instructions, then the new flow
        repeat (20) begin
            plain_step(JAL, 1'b0, 1'b0);
            plain_step(op_e'($urandom_range(int'(LUI), int'(ADD))), 1'b0, 1'b1);
            plain_step(op_e'($urandom_range(int'(BGEU), int'(JAL))), 1'b0, 1'b1);
            step(ECALL, $urandom(), $urandom(), $urandom(), $urandom(),
                 1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
            plain_step(ADD, 1'b0, 1'b0);
        end
        close_test("kill_after_redirect");

        for (int i = 0; i < 32; i++) begin
            case (i[3:2])
                2'd0:    op = ADD;
                2'd1:    op = ECALL;
                2'd2:    op = EBREAK;
                default: op = MRET;
            endcase
            step(op, $urandom(), $urandom(), $urandom(), $urandom(),
                 i[0], i[1], i[4], 1'b0, 1'b0);
        end
        close_test("trap_priority");

        // Occasional JAL keeps the tag moving during a stall
        repeat (30) begin
            n = $urandom_range(5, 1);
            repeat (n) begin
                op = ($urandom_range(7, 0) == 0) ? JAL
                     : op_e'($urandom_range(int'(LUI), int'(ADD)));
                plain_step(op, 1'b1, 1'b0);
            end
            plain_step(op_e'($urandom_range(int'(LUI), int'(ADD))), 1'b0, 1'b0);
        end
        close_test("stall_hold");
    endtask

    initial begin
        int total;
        void'($urandom(32'hedccb261));
        reset             = 1'b1;
        stall             = 1'b0;
        pc                = '0;
        first_operand     = '0;
        second_operand    = '0;
        third_operand     = '0;
        operation         = NOP;
        tag               = '0;
        exc_illegal       = 1'b0;
        exc_misaligned    = 1'b0;
        irq_pending       = 1'b1;
        model_tag         = '0;
        next_active       = 1'b0;
        next_we           = 1'b0;
        next_op           = NOP;
        next_result       = '0;
        errors            = 0;
        checks            = 0;
        tests             = 0;
        test_start_errors = 0;
        // Tenth edge comes from the first step
        repeat (9) @(posedge clk);
        #1;
        wait_reset_state(reset_ok);
        if (!reset_ok) begin
            $display("Timeout: outputs never reached their reset values");
            $display("TEST FAILED");
            $finish;
        end else begin
            run_tests();
            total = errors + exec_stage_inst.exec_stage_sva_inst.failures;
            $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                     tests, checks, errors, exec_stage_inst.exec_stage_sva_inst.failures);
            if (total == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: load_store_unit.sv
// Load and store request generation: aligned address, read enable, lanes, data

`default_nettype none

`include "exec_stage_macros.svh"

module load_store_unit
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  op_e      op_i,
    input  word_t    sum_result_i,
    input  word_t    third_operand_i,
    output word_t    mem_address_o,
    output logic     mem_read_enable_o,
    output byte_en_t mem_write_enable_o,
    output word_t    mem_write_data_o
);

    logic [1:0] offset;

    assign offset = sum_result_i[1:0];

    // Word aligned, lane picked by the byte enables
    assign mem_address_o     = {sum_result_i[`XLEN-1:2], 2'b00};
    assign mem_read_enable_o = op_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // Store data and lanes
    ////////////////////////////////////////

    // Narrow stores repeat the value on every lane
    always_comb begin
        unique case (op_i)
            SB:      mem_write_data_o = {`BE_W{third_operand_i[7:0]}};
            SH:      mem_write_data_o = {(`BE_W/2){third_operand_i[15:0]}};
            default: mem_write_data_o = third_operand_i;
        endcase
    end

    always_comb begin
        unique case (op_i)
            SB: begin
                unique case (offset)
                    2'b00: mem_write_enable_o = 4'b0001;
                    2'b01: mem_write_enable_o = 4'b0010;
                    2'b10: mem_write_enable_o = 4'b0100;
                    2'b11: mem_write_enable_o = 4'b1000;
                endcase
            end
            // Upper or lower half word
            SH:      mem_write_enable_o = offset[1] ? 4'b1100 : 4'b0011;
            SW:      mem_write_enable_o = 4'b1111;
            default: mem_write_enable_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
// Instruction-set types for the execute stage: decoded operations and data word

`default_nettype none

`include "exec_stage_macros.svh"

package rv_isa_pkg;

    // Register and address sized data word
    typedef logic [`XLEN-1:0] word_t;

    // Decoded operation coming from the decode stage
    typedef enum logic [5:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        LUI,
        // Unconditional jumps
        JAL,
        JALR,
        // Conditional branches
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        // Loads
        LB,
        LBU,
        LH,
        LHU,
        LW,
        // Stores
        SB,
        SH,
        SW,
        // System
        ECALL,
        EBREAK,
        MRET,
        NOP
    } op_e;

endpackage

`default_nettype wire

// File: trap_tag_ctrl.sv
// Flow tag tracking, kill detection and prioritized trap selection

`default_nettype none

module trap_tag_ctrl
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  op_e       op_i,
    input  tag_t      tag_i,
    input  logic      exc_illegal_inst_i,
    input  logic      exc_misaligned_fetch_i,
    input  logic      interrupt_pending_i,
    input  logic      jump_i,
    output logic      killed_o,
    output logic      raise_exception_o,
    output logic      machine_return_o,
    output logic      interrupt_ack_o,
    output exc_code_e exception_code_o
);

    tag_t curr_tag;
    logic redirect;

    // Instruction belongs to an abandoned flow
    assign killed_o = (curr_tag != tag_i);

    ////////////////////////////////////////
    // Trap select
    ////////////////////////////////////////

    // Illegal > misaligned > ECALL > EBREAK > MRET > interrupt
    always_comb begin
        raise_exception_o = 1'b0;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        exception_code_o  = NE;
        if (!killed_o && !reset) begin
            if (exc_illegal_inst_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ILLEGAL_INSTRUCTION;
            end else if (exc_misaligned_fetch_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op_i == ECALL) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ECALL_FROM_MMODE;
            end else if (op_i == EBREAK) begin
                raise_exception_o = 1'b1;
                exception_code_o  = BREAKPOINT;
            end else if (op_i == MRET) begin
                machine_return_o = 1'b1;
            end else if (interrupt_pending_i) begin
                interrupt_ack_o = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Tag register
    ////////////////////////////////////////

    // Any change of flow invalidates younger instructions
    assign redirect = jump_i | raise_exception_o | machine_return_o | interrupt_ack_o;

    // Runs through stalls as well
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (redirect) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

`default_nettype wire
